// ==== project.f ====
hw/burst_merge_pkg.sv
hw/fixed_prio_arb.sv
hw/lock_arb.sv
hw/grant_data_mux.sv
hw/burst_meter.sv
hw/burst_merge_top.sv
test/tb_burst_merge.sv

// ==== Makefile ====
# Verilator build and run for the burst merge testbench
# override any variable on the command line, e.g. make run LOG=my.log

VERILATOR  ?= verilator
TOP        ?= tb_burst_merge
LOG        ?= sim.log
SEED_FLAGS ?=
BUILD_DIR  ?= obj_dir
FILELIST   ?= project.f

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --assert --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# the simulation passes only if the log holds the pass message
run: compile
	./$(SIM_BIN) $(SEED_FLAGS) 2>&1 | tee $(LOG)
	@grep -q -F -- '*** PASSED ***' $(LOG) || \
		(echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_burst_merge.sv ====
// testbench for the burst merge top level
// xorshift burst scripts, cycle-level reference model and assertion checks

`timescale 1ns/1ps

module tb_burst_merge;

  localparam int inputs_lp          = burst_merge_pkg::DEF_INPUTS;
  localparam int width_lp           = burst_merge_pkg::DEF_WIDTH;
  localparam int len_width_lp       = burst_merge_pkg::DEF_LEN_WIDTH;
  localparam int owner_w_lp         = burst_merge_pkg::owner_w(inputs_lp);
  localparam int max_len_lp         = 6;
  localparam int rand_bursts_lp     = 60;
  localparam int directed_cycles_lp = 40;
  localparam int timeout_cycles_lp  =
    (directed_cycles_lp + rand_bursts_lp * max_len_lp * inputs_lp) * 2;

  logic                            clk_i;
  logic                            arst_n_i;
  logic                            ready_i;
  logic [inputs_lp-1:0]            reqs_i;
  logic [inputs_lp-1:0]            switch_lock_i;
  logic [inputs_lp*width_lp-1:0]   data_i;
  logic [inputs_lp-1:0]            grants_o;
  logic                            lock_o;
  logic                            valid_o;
  logic [width_lp-1:0]             data_o;
  logic                            last_o;
  logic [owner_w_lp-1:0]           owner_o;
  logic                            burst_done_o;
  logic [owner_w_lp-1:0]           burst_owner_o;
  logic [len_width_lp-1:0]         burst_len_o;

  int          rem [inputs_lp]; // beats left in each source's current burst
  int          bursts_left;
  int          errors = 0;
  int          cycle = 0;
  int          reports = 0;
  logic [31:0] rng_state = 32'hd129447d;

  // reference model state and predictions
  burst_merge_pkg::lock_state_e m_state;
  logic [owner_w_lp-1:0]        m_owner;
  int                           m_cnt;
  logic [inputs_lp-1:0]         exp_grants;
  logic [owner_w_lp-1:0]        exp_idx;
  logic [width_lp-1:0]          exp_word;
  logic                         exp_glock;
  logic                         owner_lock;
  logic                         exp_lock;
  logic                         found;
  logic                         exp_valid;
  logic                         exp_last;
  logic [width_lp-1:0]          exp_data;
  logic [owner_w_lp-1:0]        exp_owner;
  logic                         rep_pend;
  logic [owner_w_lp-1:0]        rep_owner;
  logic [len_width_lp-1:0]      rep_len;
  logic                         exp_done;
  logic [owner_w_lp-1:0]        exp_bowner;
  logic [len_width_lp-1:0]      exp_blen;

  burst_merge_top #(
    .lo_to_hi_p(1)
  ) dut_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .reqs_i       (reqs_i),
    .switch_lock_i(switch_lock_i),
    .data_i       (data_i),
    .ready_i      (ready_i),
    .grants_o     (grants_o),
    .lock_o       (lock_o),
    .valid_o      (valid_o),
    .data_o       (data_o),
    .last_o       (last_o),
    .owner_o      (owner_o),
    .burst_done_o (burst_done_o),
    .burst_owner_o(burst_owner_o),
    .burst_len_o  (burst_len_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic void report_error(string name, logic [31:0] expected, logic [31:0] actual);
    errors = errors + 1;
    $display("[ERROR] %s at %0t: expected 0x%0h, actual 0x%0h", name, $time, expected, actual);
  endfunction

  // first requester from index 0 wins, and a held channel only serves its owner
  always_comb
  begin
    found      = 1'b0;
    exp_grants = '0;
    exp_idx    = '0;
    exp_word   = '0;
    exp_glock  = 1'b0;
    owner_lock = 1'b0;
    for (int i = 0; i < inputs_lp; i++)
    begin
      if (owner_w_lp'(i) == m_owner)
      begin
        owner_lock = switch_lock_i[i];
      end
      if (ready_i && !found && reqs_i[i] &&
          (m_state == burst_merge_pkg::LOCK_FREE || owner_w_lp'(i) == m_owner))
      begin
        found         = 1'b1;
        exp_grants[i] = 1'b1;
        exp_idx       = owner_w_lp'(i);
        exp_word      = data_i[i*width_lp +: width_lp];
        exp_glock     = switch_lock_i[i];
      end
    end
    exp_lock = (m_state == burst_merge_pkg::LOCK_HELD) ? owner_lock : exp_glock;
  end

  always @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      m_state    <= burst_merge_pkg::LOCK_FREE;
      m_owner    <= '0;
      m_cnt      <= 0;
      exp_valid  <= 1'b0;
      exp_last   <= 1'b0;
      exp_data   <= '0;
      exp_owner  <= '0;
      rep_pend   <= 1'b0;
      rep_owner  <= '0;
      rep_len    <= '0;
      exp_done   <= 1'b0;
      exp_bowner <= '0;
      exp_blen   <= '0;
    end
    else
    begin
      exp_valid <= found;
      exp_last  <= found && !exp_glock;
      rep_pend  <= found && !exp_glock; // report follows one cycle after the last beat
      exp_done  <= rep_pend;
      if (found)
      begin
        exp_data  <= exp_word;
        exp_owner <= exp_idx;
        if (exp_glock)
        begin
          m_state <= burst_merge_pkg::LOCK_HELD;
          m_owner <= exp_idx;
          m_cnt   <= m_cnt + 1;
        end
        else
        begin
          m_state   <= burst_merge_pkg::LOCK_FREE;
          rep_owner <= exp_idx;
          rep_len   <= len_width_lp'(m_cnt + 1);
          m_cnt     <= 0;
        end
      end
      if (rep_pend)
      begin
        exp_bowner <= rep_owner;
        exp_blen   <= rep_len;
      end
    end
  end

  a_grants : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    grants_o == exp_grants) else report_error("grant select", 32'(exp_grants), 32'(grants_o));
  a_lock : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    lock_o == exp_lock) else report_error("lock level", 32'(exp_lock), 32'(lock_o));
  a_valid : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_o == exp_valid) else report_error("output valid", 32'(exp_valid), 32'(valid_o));
  a_data : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    exp_valid |-> (data_o == exp_data)) else report_error("output data", 32'(exp_data), 32'(data_o));
  a_last : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    last_o == exp_last) else report_error("last flag", 32'(exp_last), 32'(last_o));
  a_owner : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    exp_valid |-> (owner_o == exp_owner))
    else report_error("output owner", 32'(exp_owner), 32'(owner_o));
  a_done : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    burst_done_o == exp_done) else report_error("burst done", 32'(exp_done), 32'(burst_done_o));
  a_bowner : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    exp_done |-> (burst_owner_o == exp_bowner))
    else report_error("burst owner", 32'(exp_bowner), 32'(burst_owner_o));
  a_blen : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    exp_done |-> (burst_len_o == exp_blen))
    else report_error("burst length", 32'(exp_blen), 32'(burst_len_o));
  a_reset : assert property (@(posedge clk_i)
    (!arst_n_i && cycle > 1) |-> (!valid_o && !last_o && !burst_done_o))
    else report_error("reset values", 32'd0, 32'({valid_o, last_o, burst_done_o}));

  // a beat seen on the channel retires one beat of its source's script
  task automatic account_beat();
    if (valid_o && rem[owner_o] > 0)
    begin
      rem[owner_o] = rem[owner_o] - 1;
    end
  endtask

  task automatic drive_random();
    logic [31:0] r;
    for (int i = 0; i < inputs_lp; i++)
    begin
      r = next_random();
      if (rem[i] == 0 && bursts_left > 0 && r[31])
      begin
        rem[i]      = 1 + int'(r % 32'(max_len_lp));
        bursts_left = bursts_left - 1;
      end
      reqs_i[i]        = (rem[i] > 0);
      switch_lock_i[i] = (rem[i] > 1); // lock drops on the final beat
      data_i[i*width_lp +: width_lp] = r[width_lp-1:0];
    end
    r = next_random();
    ready_i = (r[1:0] != 2'b00); // roughly one stall cycle in four
  endtask

  task automatic run_bursts(input int count);
    logic busy;
    bursts_left = count;
    busy = 1'b1;
    while (busy)
    begin
      @(negedge clk_i);
      account_beat();
      busy = (bursts_left > 0);
      for (int i = 0; i < inputs_lp; i++)
      begin
        if (rem[i] > 0)
        begin
          busy = 1'b1;
        end
      end
      if (busy)
      begin
        drive_random();
      end
    end
    reqs_i        = '0;
    switch_lock_i = '0;
    ready_i       = 1'b1;
  endtask

  // source 1 ends a two-beat burst and source 0 takes the channel, so reset
  // hits while the channel is held and the burst report is out
  task automatic reset_mid_burst();
    @(negedge clk_i);
    reqs_i        = 4'b0010;
    switch_lock_i = 4'b0010;
    data_i        = {next_random(), next_random()};
    @(negedge clk_i);
    reqs_i        = 4'b0011; // source 0 stays masked behind the owner
    switch_lock_i = 4'b0001; // final beat of source 1
    @(negedge clk_i);
    reqs_i        = 4'b0001;
    switch_lock_i = 4'b0001; // source 0 locks the channel
    @(negedge clk_i);
    arst_n_i      = 1'b0;
    reqs_i        = '0;
    switch_lock_i = '0;
    repeat (10) @(negedge clk_i);
    arst_n_i = 1'b1;
    reqs_i   = 4'b1000; // a lock kept over reset would block source 3
    data_i   = {next_random(), next_random()};
    @(negedge clk_i);
    reqs_i = '0;
    repeat (3) @(negedge clk_i);
  endtask

  always @(posedge clk_i)
  begin
    cycle <= cycle + 1;
    if (burst_done_o)
    begin
      reports <= reports + 1;
    end
  end

  initial
  begin
    while (cycle < timeout_cycles_lp)
    begin
      @(posedge clk_i);
    end
    $display("timeout: the run did not finish within %0d cycles", timeout_cycles_lp);
    $display("*** FAILED ***");
    $finish;
  end

  initial
  begin
    arst_n_i      = 1'b0;
    ready_i       = 1'b0;
    reqs_i        = '0;
    switch_lock_i = '0;
    data_i        = '0;
    for (int i = 0; i < inputs_lp; i++)
    begin
      rem[i] = 0;
    end
    repeat (10) @(negedge clk_i);
    arst_n_i = 1'b1;
    run_bursts(rand_bursts_lp / 2);
    reset_mid_burst();
    run_bursts(rand_bursts_lp - rand_bursts_lp / 2);
    repeat (4) @(negedge clk_i);
    $display("run ended after %0d cycles with %0d burst reports and %0d errors",
             cycle, reports, errors);
    if (errors == 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== hw/burst_merge_top.sv ====
// top level of the burst merge subsystem
// lock arbiter, output channel register and burst meter

`timescale 1ns/1ps

module burst_merge_top #(
  parameter int inputs_p    = burst_merge_pkg::DEF_INPUTS,
  parameter int width_p     = burst_merge_pkg::DEF_WIDTH,
  parameter int lo_to_hi_p  = 0,
  parameter int len_width_p = burst_merge_pkg::DEF_LEN_WIDTH
) (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,

  // source side
  input  logic [inputs_p-1:0]                           reqs_i,
  input  logic [inputs_p-1:0]                           switch_lock_i,
  input  logic [inputs_p*width_p-1:0]                   data_i,
  input  logic                                          ready_i,

  // arbitration, same cycle as the request
  output logic [inputs_p-1:0]                           grants_o,
  output logic                                          lock_o,

  // output channel, one cycle after the grant
  output logic                                          valid_o,
  output logic [width_p-1:0]                            data_o,
  output logic                                          last_o,
  output logic [burst_merge_pkg::owner_w(inputs_p)-1:0] owner_o,

  // burst report, one cycle after the last beat
  output logic                                          burst_done_o,
  output logic [burst_merge_pkg::owner_w(inputs_p)-1:0] burst_owner_o,
  output logic [len_width_p-1:0]                        burst_len_o
);

  lock_arb #(
    .inputs_p  (inputs_p),
    .lo_to_hi_p(lo_to_hi_p)
  ) lock_arb_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .ready_i      (ready_i),
    .switch_lock_i(switch_lock_i),
    .reqs_i       (reqs_i),
    .grants_o     (grants_o),
    .lock_o       (lock_o)
  );

  // grants_o feeds the output register directly
  grant_data_mux #(
    .inputs_p(inputs_p),
    .width_p (width_p)
  ) grant_data_mux_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .grants_i     (grants_o),
    .switch_lock_i(switch_lock_i),
    .data_i       (data_i),
    .valid_o      (valid_o),
    .data_o       (data_o),
    .last_o       (last_o),
    .owner_o      (owner_o)
  );

  // the meter watches the registered channel, not the grants
  burst_meter #(
    .inputs_p   (inputs_p),
    .len_width_p(len_width_p)
  ) burst_meter_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .valid_i      (valid_o),
    .last_i       (last_o),
    .owner_i      (owner_o),
    .burst_done_o (burst_done_o),
    .burst_owner_o(burst_owner_o),
    .burst_len_o  (burst_len_o)
  );

endmodule

// ==== hw/burst_meter.sv ====
// burst meter on the output channel
// counts beats and reports owner and length once the last beat is seen

`timescale 1ns/1ps

module burst_meter #(
  parameter int inputs_p    = 4,
  parameter int len_width_p = 8
) (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  input  logic                                          valid_i,
  input  logic                                          last_i,
  input  logic [burst_merge_pkg::owner_w(inputs_p)-1:0] owner_i,
  output logic                                          burst_done_o,
  output logic [burst_merge_pkg::owner_w(inputs_p)-1:0] burst_owner_o,
  output logic [len_width_p-1:0]                        burst_len_o
);

  localparam logic [len_width_p-1:0] len_max_lp = '1;

  logic [len_width_p-1:0] count_q;    // beats of the open burst so far
  logic [len_width_p-1:0] count_next; // count including the current beat

  // saturate rather than wrap on very long bursts
  assign count_next = (count_q == len_max_lp) ? count_q : count_q + 1'b1;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      count_q      <= '0;
      burst_done_o <= 1'b0;
      burst_len_o  <= '0;
    end
    else
    begin
      burst_done_o <= 1'b0;
      if (valid_i)
      begin
        if (last_i)
        begin
          burst_done_o <= 1'b1;
          burst_len_o  <= count_next; // the last beat counts too
          count_q      <= '0;
        end
        else
        begin
          count_q <= count_next;
        end
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (valid_i && last_i)
    begin
      burst_owner_o <= owner_i;
    end
  end

  // the upstream register holds owner_i between beats, so after any
  // non-final beat the next cycle must still show the same owner
  a_owner_stable : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (valid_i && !last_i) |=> (owner_i == $past(owner_i))
  );

endmodule

// ==== hw/grant_data_mux.sv ====
// output channel register fed by the granted source
// one-hot data select, index encode and last flag from the lock bit

`timescale 1ns/1ps

module grant_data_mux #(
  parameter int inputs_p = 4,
  parameter int width_p  = 16
) (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  input  logic [inputs_p-1:0]                           grants_i,
  input  logic [inputs_p-1:0]                           switch_lock_i,
  input  logic [inputs_p*width_p-1:0]                   data_i,
  output logic                                          valid_o,
  output logic [width_p-1:0]                            data_o,
  output logic                                          last_o,
  output logic [burst_merge_pkg::owner_w(inputs_p)-1:0] owner_o
);

  localparam int owner_w_lp = burst_merge_pkg::owner_w(inputs_p);

  logic [width_p-1:0]    sel_data;
  logic [owner_w_lp-1:0] sel_idx;
  logic                  sel_lock;
  logic                  any_grant;

  assign any_grant = |grants_i;

  // grants are one-hot, so OR-ing the gated words picks exactly one
  always_comb
  begin
    sel_data = '0;
    sel_idx  = '0;
    for (int i = 0; i < inputs_p; i++)
    begin
      sel_data = sel_data | (data_i[i*width_p +: width_p] & {width_p{grants_i[i]}});
      if (grants_i[i])
      begin
        sel_idx = owner_w_lp'(i);
      end
    end
  end

  assign sel_lock = |(switch_lock_i & grants_i);

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      valid_o <= 1'b0;
      last_o  <= 1'b0;
    end
    else
    begin
      valid_o <= any_grant;
      last_o  <= any_grant & ~sel_lock; // a low lock bit marks the final beat
    end
  end

  // payload holds its value between beats, so owner_o is stable across stalls
  always_ff @(posedge clk_i)
  begin
    if (any_grant)
    begin
      data_o  <= sel_data;
      owner_o <= sel_idx;
    end
  end

  a_sel_onehot : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(grants_i)
  );

endmodule

// ==== hw/lock_arb.sv ====
// lock arbiter for wormhole-style bursts
// keeps the channel with the owner while its lock level stays high

`timescale 1ns/1ps

module lock_arb #(
  parameter int inputs_p   = 4,
  parameter int lo_to_hi_p = 0
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                ready_i,
  input  logic [inputs_p-1:0] switch_lock_i, // high means more beats follow
  input  logic [inputs_p-1:0] reqs_i,
  output logic [inputs_p-1:0] grants_o,
  output logic                lock_o
);

  burst_merge_pkg::lock_state_e state_q;
  logic [inputs_p-1:0]          owner_mask_q; // one-hot, valid while held

  logic                held;
  logic [inputs_p-1:0] req_mask;
  logic [inputs_p-1:0] masked_reqs;
  logic                owner_lock;
  logic                granted_lock;
  logic                unlock;

  assign held = (state_q == burst_merge_pkg::LOCK_HELD);

  // while held only the owner may compete, even in its final beat
  assign req_mask    = held ? owner_mask_q : {inputs_p{1'b1}};
  assign masked_reqs = reqs_i & req_mask;

  fixed_prio_arb #(
    .inputs_p  (inputs_p),
    .lo_to_hi_p(lo_to_hi_p)
  ) prio_arb_i (
    .ready_i (ready_i),
    .reqs_i  (masked_reqs),
    .grants_o(grants_o)
  );

  assign owner_lock   = |(switch_lock_i & owner_mask_q); // lock bit of the stored owner
  assign granted_lock = |(switch_lock_i & grants_o);     // lock bit of this cycle's winner

  // the owner's low lock bit frees the channel after its final beat goes out,
  // so a stalled burst keeps its owner until ready_i returns
  assign unlock = held & ~owner_lock & (|grants_o);

  // lock_o follows the owner in the same cycle, as the release is combinational
  assign lock_o = held ? owner_lock : granted_lock;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q      <= burst_merge_pkg::LOCK_FREE;
      owner_mask_q <= '0;
    end
    else if (!held)
    begin
      if ((|grants_o) && granted_lock)
      begin
        state_q      <= burst_merge_pkg::LOCK_HELD; // first beat of a multi-beat burst
        owner_mask_q <= grants_o;
      end
    end
    else if (unlock)
    begin
      state_q      <= burst_merge_pkg::LOCK_FREE;
      owner_mask_q <= '0;
    end
  end

  a_grant_onehot : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(grants_o)
  );

  a_no_grant_stalled : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !ready_i |-> (grants_o == '0)
  );

  // a held channel can only ever serve the owner recorded at lock time
  a_held_owner_only : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    held |-> ((grants_o == '0) || (grants_o == owner_mask_q))
  );

endmodule

// ==== hw/fixed_prio_arb.sv ====
// fixed-priority grant encoder, combinational
// grants at most one request, and only while ready_i is high

`timescale 1ns/1ps

module fixed_prio_arb #(
  parameter int inputs_p   = 4,
  parameter int lo_to_hi_p = 0 // 1 gives index 0 the highest priority
) (
  input  logic                ready_i,
  input  logic [inputs_p-1:0] reqs_i,
  output logic [inputs_p-1:0] grants_o
);

  // the scan walks from the lowest to the highest priority, so the
  // last request found wins and clears any earlier pick
  always_comb
  begin
    grants_o = '0;
    if (ready_i)
    begin
      if (lo_to_hi_p != 0)
      begin
        for (int i = inputs_p - 1; i >= 0; i--)
        begin
          if (reqs_i[i])
          begin
            grants_o    = '0;
            grants_o[i] = 1'b1;
          end
        end
      end
      else
      begin
        for (int i = 0; i < inputs_p; i++)
        begin
          if (reqs_i[i])
          begin
            grants_o    = '0;
            grants_o[i] = 1'b1;
          end
        end
      end
    end
  end

endmodule

// ==== hw/burst_merge_pkg.sv ====
// shared definitions for the burst merge subsystem
// lock state enum, default sizes and the source index width helper

package burst_merge_pkg;

  // stored state of the lock arbiter
  typedef enum logic
  {
    LOCK_FREE = 1'b0, // channel open to any requester
    LOCK_HELD = 1'b1  // one source owns the channel until its final beat
  } lock_state_e;

  localparam int DEF_INPUTS    = 4;  // number of sources
  localparam int DEF_WIDTH     = 16; // data word width in bits
  localparam int DEF_LEN_WIDTH = 8;  // burst length counter width

  // width of a source index, never less than one bit
  function automatic int owner_w(input int inputs);
    int w;
    w = $clog2(inputs);
    if (w < 1)
    begin
      w = 1;
    end
    return w;
  endfunction

endpackage
